// ==== verilog/mmu_config.svh ====
`ifndef MMU_CONFIG_SVH
`define MMU_CONFIG_SVH

// --------------------
// TLB geometry
// --------------------

`define MMU_ENTRIES 16
`define MMU_INDEX_BITS 4

// --------------------
// Unmapped window
// --------------------

// Top two address bits that bypass the TLB, 0x80000000 to 0xBFFFFFFF.
`define MMU_KSEG_LOW 2'b10
`define MMU_KSEG_HIGH 2'b10

`endif

// ==== verilog/tlbPkg.sv ====
`default_nettype none

`include "mmu_config.svh"

package tlbPkg;

  // --------------------
  // Address types
  // --------------------

  typedef logic [31:0] vaddr_t;
  typedef logic [31:0] paddr_t;

  typedef logic [`MMU_INDEX_BITS-1:0] tlbIndex_t;

  // --------------------
  // TLB entry
  // --------------------

  // One entry maps an even/odd pair of 4 KiB pages. Bit 70 is the top of vpn2.
  typedef struct packed {
    logic [18:0] vpn2;   // Virtual address bits 31:13.
    logic [23:0] pfn1;   // Frame of the odd page.
    logic        dirty1;
    logic        valid1;
    logic [23:0] pfn0;   // Frame of the even page.
    logic        dirty0;
    logic        valid0;
  } tlbEntry_t;

endpackage

`default_nettype wire

// ==== verilog/tlbEntryFile.sv ====
`default_nettype none

`include "mmu_config.svh"

module tlbEntryFile import tlbPkg::*; (
  input  wire              clk,
  input  wire              reset,

  // Indexed write for tlbwi.
  input  wire              writeEnable,
  input  wire tlbIndex_t   writeIndex,
  input  wire tlbEntry_t   writeEntry,

  // Clears every valid bit, ahead of a write in the same cycle.
  input  wire              flush,

  // Indexed read for tlbr.
  input  wire tlbIndex_t   readIndex,
  output tlbEntry_t        readEntry,

  // Whole array for the lookup ports.
  output tlbEntry_t        entries [`MMU_ENTRIES]
);

  // --------------------
  // Entry storage
  // --------------------

  // Only the valid bits are cleared. A stale vpn2 or pfn cannot match once
  // both of its valid bits are low.
  always_ff @(posedge clk) begin
    if (reset || flush) begin
      for (int i = 0; i < `MMU_ENTRIES; i++) begin
        entries[i].valid0 <= 1'b0;
        entries[i].valid1 <= 1'b0;
      end
    end else if (writeEnable) begin
      entries[writeIndex] <= writeEntry; // The whole entry is replaced.
    end
  end

  // --------------------
  // Read port
  // --------------------

  assign readEntry = entries[readIndex]; // Combinational, same cycle as readIndex.

endmodule

`default_nettype wire

// ==== verilog/tlbLookup.sv ====
`default_nettype none

`include "mmu_config.svh"

module tlbLookup import tlbPkg::*; (
  input  wire              clk,
  input  wire              reset,

  // Request, sampled on the rising edge.
  input  wire              lookupValid,
  input  wire vaddr_t      virtAddr,
  input  wire              isStore,

  input  wire tlbEntry_t   entries [`MMU_ENTRIES],

  // Result, valid for one cycle after the request.
  output logic             resultValid,
  output paddr_t           physAddr,
  output logic             miss,
  output logic             modFault,
  output tlbIndex_t        hitIndex
);

  logic [`MMU_ENTRIES-1:0] matched;
  tlbIndex_t               matchIndex;
  tlbEntry_t               selEntry;
  logic [19:0]             selPfn;
  logic                    selDirty;
  logic                    hit;
  logic                    bypass;

  paddr_t                  nextPhys;
  logic                    nextMiss;
  logic                    nextFault;
  tlbIndex_t               nextIndex;

  // --------------------
  // Associative match
  // --------------------

  for (genvar i = 0; i < `MMU_ENTRIES; i++) begin : g_match
    // Bit 12 picks which half of the pair has to be valid.
    assign matched[i] = (entries[i].vpn2 == virtAddr[31:13]) &&
                        (virtAddr[12] ? entries[i].valid1 : entries[i].valid0);
  end

  // Scanning downwards leaves the lowest matching index in matchIndex.
  always_comb begin
    matchIndex = '0;
    for (int i = `MMU_ENTRIES - 1; i >= 0; i--) begin
      if (matched[i]) begin
        matchIndex = tlbIndex_t'(i);
      end
    end
  end

  assign hit = |matched;

  // --------------------
  // Page half select
  // --------------------

  assign selEntry = entries[matchIndex];
  assign selPfn   = virtAddr[12] ? selEntry.pfn1[19:0] : selEntry.pfn0[19:0];
  assign selDirty = virtAddr[12] ? selEntry.dirty1 : selEntry.dirty0;

  // kseg0 and kseg1 are both unmapped here.
  assign bypass = (virtAddr[31:30] >= `MMU_KSEG_LOW) &&
                  (virtAddr[31:30] <= `MMU_KSEG_HIGH);

  always_comb begin
    if (bypass) begin
      nextPhys  = {3'b000, virtAddr[28:0]};
      nextMiss  = 1'b0;
      nextFault = 1'b0;
      nextIndex = '0;
    end else if (hit) begin
      nextPhys  = {selPfn, virtAddr[11:0]};
      nextMiss  = 1'b0;
      nextFault = isStore && !selDirty; // Store to a clean page.
      nextIndex = matchIndex;
    end else begin
      nextPhys  = '0;
      nextMiss  = 1'b1;
      nextFault = 1'b0;
      nextIndex = '0;
    end
  end

  // --------------------
  // Result register
  // --------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      resultValid <= 1'b0;
    end else begin
      resultValid <= lookupValid; // One-cycle strobe per request.
    end
  end

  // Loaded only on a request, so the result holds between strobes.
  always_ff @(posedge clk) begin
    if (lookupValid) begin
      physAddr <= nextPhys;
      miss     <= nextMiss;
      modFault <= nextFault;
      hitIndex <= nextIndex;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/mmuTlb.sv ====
`default_nettype none

`include "mmu_config.svh"

module mmuTlb import tlbPkg::*; (
  input  wire              clk,
  input  wire              reset,

  // --------------------
  // Entry maintenance
  // --------------------

  input  wire              writeEnable,
  input  wire tlbIndex_t   writeIndex,
  input  wire tlbEntry_t   writeEntry,
  input  wire              flush,
  input  wire tlbIndex_t   readIndex,
  output tlbEntry_t        readEntry,

  // --------------------
  // Fetch port
  // --------------------

  input  wire              fetchReq,
  input  wire vaddr_t      fetchAddr,
  output logic             fetchDone,
  output paddr_t           fetchPhys,
  output logic             fetchMiss,

  // --------------------
  // Data port
  // --------------------

  input  wire              dataReq,
  input  wire vaddr_t      dataAddr,
  input  wire              dataStore,
  output logic             dataDone,
  output paddr_t           dataPhys,
  output logic             dataMiss,
  output logic             dataModFault,
  output tlbIndex_t        dataHitIndex // Also the tlbp probe result.
);

  tlbEntry_t entries [`MMU_ENTRIES];

  tlbEntryFile entryFile (
    .clk         (clk),
    .reset       (reset),
    .writeEnable (writeEnable),
    .writeIndex  (writeIndex),
    .writeEntry  (writeEntry),
    .flush       (flush),
    .readIndex   (readIndex),
    .readEntry   (readEntry),
    .entries     (entries)
  );

  // Instruction fetches never store, so no modify fault is possible.
  tlbLookup fetchLookup (
    .clk         (clk),
    .reset       (reset),
    .lookupValid (fetchReq),
    .virtAddr    (fetchAddr),
    .isStore     (1'b0),
    .entries     (entries),
    .resultValid (fetchDone),
    .physAddr    (fetchPhys),
    .miss        (fetchMiss),
    .modFault    (),
    .hitIndex    ()
  );

  tlbLookup dataLookup (
    .clk         (clk),
    .reset       (reset),
    .lookupValid (dataReq),
    .virtAddr    (dataAddr),
    .isStore     (dataStore),
    .entries     (entries),
    .resultValid (dataDone),
    .physAddr    (dataPhys),
    .miss        (dataMiss),
    .modFault    (dataModFault),
    .hitIndex    (dataHitIndex)
  );

endmodule

`default_nettype wire

// ==== bench/mmuTlb_assert.sv ====
`default_nettype none

`include "mmu_config.svh"

module mmuTlb_assert import tlbPkg::*; (
  input wire         clk,
  input wire         reset,
  input wire         fetchReq,
  input wire vaddr_t fetchAddr,
  input wire         fetchDone,
  input wire         fetchMiss,
  input wire         dataReq,
  input wire vaddr_t dataAddr,
  input wire         dataDone,
  input wire         dataMiss
);

  logic fetchInWindow;
  logic dataInWindow;

  assign fetchInWindow = (fetchAddr[31:30] == `MMU_KSEG_LOW);
  assign dataInWindow  = (dataAddr[31:30] == `MMU_KSEG_LOW);

  // --------------------
  // Result strobes
  // --------------------

  fetchDoneTiming: assert property (@(posedge clk) disable iff (reset)
    fetchDone == $past(fetchReq))
    else $error("fetchDone does not follow fetchReq by one cycle");

  dataDoneTiming: assert property (@(posedge clk) disable iff (reset)
    dataDone == $past(dataReq))
    else $error("dataDone does not follow dataReq by one cycle");

  // --------------------
  // Unmapped window
  // --------------------

  fetchBypassHit: assert property (@(posedge clk) disable iff (reset)
    (fetchDone && $past(fetchInWindow)) |-> !fetchMiss)
    else $error("Fetch miss reported in the unmapped window");

  dataBypassHit: assert property (@(posedge clk) disable iff (reset)
    (dataDone && $past(dataInWindow)) |-> !dataMiss)
    else $error("Data miss reported in the unmapped window");

endmodule

bind mmuTlb mmuTlb_assert mmuTlbChecks (
  .clk       (clk),
  .reset     (reset),
  .fetchReq  (fetchReq),
  .fetchAddr (fetchAddr),
  .fetchDone (fetchDone),
  .fetchMiss (fetchMiss),
  .dataReq   (dataReq),
  .dataAddr  (dataAddr),
  .dataDone  (dataDone),
  .dataMiss  (dataMiss)
);

`default_nettype wire

// ==== bench/mmuTlbTb.sv ====
`default_nettype none

module mmuTlbTb import tlbPkg::*; ();

  localparam string testsFile = "bench/mmuTlb_tests.txt";

  logic      clk = 1'b0;
  logic      reset;
  logic      writeEnable;
  tlbIndex_t writeIndex;
  tlbEntry_t writeEntry;
  logic      flush;
  tlbIndex_t readIndex;
  tlbEntry_t readEntry;
  logic      fetchReq;
  vaddr_t    fetchAddr;
  logic      fetchDone;
  paddr_t    fetchPhys;
  logic      fetchMiss;
  logic      dataReq;
  vaddr_t    dataAddr;
  logic      dataStore;
  logic      dataDone;
  paddr_t    dataPhys;
  logic      dataMiss;
  logic      dataModFault;
  tlbIndex_t dataHitIndex;

  int fd;
  int testNum = 0;
  int cycles = 0;
  int cycleLimit = 100;
  int addrErrors = 0;
  int flagErrors = 0;
  int indexErrors = 0;
  int entryErrors = 0;
  int otherErrors = 0;
  int totalErrors;

  mmuTlb mmuTlb_i (
    .clk          (clk),
    .reset        (reset),
    .writeEnable  (writeEnable),
    .writeIndex   (writeIndex),
    .writeEntry   (writeEntry),
    .flush        (flush),
    .readIndex    (readIndex),
    .readEntry    (readEntry),
    .fetchReq     (fetchReq),
    .fetchAddr    (fetchAddr),
    .fetchDone    (fetchDone),
    .fetchPhys    (fetchPhys),
    .fetchMiss    (fetchMiss),
    .dataReq      (dataReq),
    .dataAddr     (dataAddr),
    .dataStore    (dataStore),
    .dataDone     (dataDone),
    .dataPhys     (dataPhys),
    .dataMiss     (dataMiss),
    .dataModFault (dataModFault),
    .dataHitIndex (dataHitIndex)
  );

  always #10 clk = ~clk; // Period of 20.

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycleLimit) begin
      $display("Timeout: the tests did not finish within %0d cycles", cycleLimit);
      $display("** FAIL **");
      $finish;
    end
  end

  // --------------------
  // Compare tasks
  // --------------------

  function automatic string describe(input string sig);
    return $sformatf("test %0d %s", testNum, sig);
  endfunction

  task automatic checkAddr(input paddr_t got, input paddr_t exp, input string what);
    if (got !== exp) begin
      $display("[FAIL] %0t: %s is %h, expected %h", $time, what, got, exp);
      addrErrors++;
    end
  endtask

  task automatic checkFlag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("[FAIL] %0t: %s is %b, expected %b", $time, what, got, exp);
      flagErrors++;
    end
  endtask

  task automatic checkIndex(input tlbIndex_t got, input tlbIndex_t exp, input string what);
    if (got !== exp) begin
      $display("[FAIL] %0t: %s is %0d, expected %0d", $time, what, got, exp);
      indexErrors++;
    end
  endtask

  task automatic checkEntry(input tlbEntry_t got, input tlbEntry_t exp, input string what);
    if (got !== exp) begin
      $display("[FAIL] %0t: %s is %h, expected %h", $time, what, got, exp);
      entryErrors++;
    end
  endtask

  task automatic expectFetch(input paddr_t phys, input logic missExp);
    checkFlag(fetchDone, 1'b1, describe("fetchDone"));
    checkAddr(fetchPhys, phys, describe("fetchPhys"));
    checkFlag(fetchMiss, missExp, describe("fetchMiss"));
  endtask

  task automatic expectData(input paddr_t phys, input logic missExp, input logic faultExp,
                            input tlbIndex_t idxExp);
    checkFlag(dataDone, 1'b1, describe("dataDone"));
    checkAddr(dataPhys, phys, describe("dataPhys"));
    checkFlag(dataMiss, missExp, describe("dataMiss"));
    checkFlag(dataModFault, faultExp, describe("dataModFault"));
    checkIndex(dataHitIndex, idxExp, describe("dataHitIndex"));
  endtask

  // --------------------
  // Tests file
  // --------------------

  task automatic stepCycle();
    @(posedge clk);
    #2; // Inputs change 2 units after the edge.
  endtask

  task automatic requireFields(input int got, input int want);
    if (got != want) begin
      $display("Test %0d in the tests file has %0d fields where %0d were expected",
               testNum, got, want);
      otherErrors++;
    end
  endtask

  task automatic skipLine();
    int c;
    c = $fgetc(fd);
    while (c != 10 && c != -1) begin
      c = $fgetc(fd);
    end
  endtask

  task automatic countLines(output int lines);
    int c;
    lines = 0;
    c = $fgetc(fd);
    while (c != -1) begin
      if (c == 10) begin
        lines++;
      end
      c = $fgetc(fd);
    end
  endtask

  task automatic readEntryFields(output tlbEntry_t e);
    logic [18:0] vpn2;
    logic [23:0] pfn1;
    logic [23:0] pfn0;
    logic        d1;
    logic        v1;
    logic        d0;
    logic        v0;
    int          code;
    code = $fscanf(fd, "%h %h %h %h %h %h %h", vpn2, pfn1, d1, v1, pfn0, d0, v0);
    requireFields(code, 7);
    e = {vpn2, pfn1, d1, v1, pfn0, d0, v0};
  endtask

  task automatic runCommands();
    string     cmd;
    int        code;
    logic      done;
    tlbIndex_t idx;
    tlbEntry_t entry;
    vaddr_t    addr;
    vaddr_t    addr2;
    logic      store;
    paddr_t    phys;
    paddr_t    phys2;
    logic      missExp;
    logic      missExp2;
    logic      faultExp;
    tlbIndex_t idxExp;
    done = 1'b0;
    while (!done) begin
      code = $fscanf(fd, "%s", cmd);
      if (code != 1) begin
        done = 1'b1;
      end else if (cmd == "#") begin
        skipLine();
      end else begin
        testNum++;
        if (cmd == "W") begin
          code = $fscanf(fd, "%h", idx);
          requireFields(code, 1);
          readEntryFields(entry);
          writeEnable = 1'b1;
          writeIndex  = idx;
          writeEntry  = entry;
          stepCycle();
          writeEnable = 1'b0;
        end else if (cmd == "X") begin
          flush = 1'b1;
          stepCycle();
          flush = 1'b0;
        end else if (cmd == "R") begin
          code = $fscanf(fd, "%h", idx);
          requireFields(code, 1);
          readEntryFields(entry);
          readIndex = idx;
          stepCycle(); // No write is active, so readEntry is settled.
          checkEntry(readEntry, entry, describe("readEntry"));
        end else if (cmd == "F") begin
          code = $fscanf(fd, "%h %h %h", addr, phys, missExp);
          requireFields(code, 3);
          fetchReq  = 1'b1;
          fetchAddr = addr;
          stepCycle();
          fetchReq = 1'b0;
          expectFetch(phys, missExp);
        end else if (cmd == "D") begin
          code = $fscanf(fd, "%h %h %h %h %h %h", addr, store, phys, missExp, faultExp, idxExp);
          requireFields(code, 6);
          dataReq   = 1'b1;
          dataAddr  = addr;
          dataStore = store;
          stepCycle();
          dataReq = 1'b0;
          expectData(phys, missExp, faultExp, idxExp);
        end else if (cmd == "C") begin
          // Write and data lookup in the same cycle.
          code = $fscanf(fd, "%h", idx);
          requireFields(code, 1);
          readEntryFields(entry);
          code = $fscanf(fd, "%h %h %h %h %h %h", addr, store, phys, missExp, faultExp, idxExp);
          requireFields(code, 6);
          writeEnable = 1'b1;
          writeIndex  = idx;
          writeEntry  = entry;
          dataReq     = 1'b1;
          dataAddr    = addr;
          dataStore   = store;
          stepCycle();
          writeEnable = 1'b0;
          dataReq     = 1'b0;
          expectData(phys, missExp, faultExp, idxExp);
        end else if (cmd == "P") begin
          code = $fscanf(fd, "%h %h %h", addr, phys, missExp);
          requireFields(code, 3);
          code = $fscanf(fd, "%h %h %h %h %h %h", addr2, store, phys2, missExp2, faultExp,
                         idxExp);
          requireFields(code, 6);
          fetchReq  = 1'b1;
          fetchAddr = addr;
          stepCycle();
          fetchReq  = 1'b0;
          dataReq   = 1'b1;
          dataAddr  = addr2;
          dataStore = store;
          expectFetch(phys, missExp);
          stepCycle();
          dataReq = 1'b0;
          expectData(phys2, missExp2, faultExp, idxExp);
        end else begin
          $display("Unknown command %s in the tests file, reading stopped", cmd);
          otherErrors++;
          done = 1'b1;
        end
      end
    end
  endtask

  // --------------------
  // Main sequence
  // --------------------

  initial begin
    int lines;
    reset       = 1'b1;
    writeEnable = 1'b0;
    writeIndex  = '0;
    writeEntry  = '0;
    flush       = 1'b0;
    readIndex   = '0;
    fetchReq    = 1'b0;
    fetchAddr   = '0;
    dataReq     = 1'b0;
    dataAddr    = '0;
    dataStore   = 1'b0;
    lines       = 0;
    fd = $fopen(testsFile, "r");
    if (fd != 0) begin
      countLines(lines);
      $fclose(fd);
      fd = $fopen(testsFile, "r");
    end
    cycleLimit = 4 * lines + 100; // Each command needs at most two cycles.
    repeat (10) @(posedge clk);
    #2;
    reset = 1'b0;
    if (fd == 0) begin
      $display("Could not open %s", testsFile);
      otherErrors++;
    end else begin
      runCommands();
      $fclose(fd);
    end
    totalErrors = addrErrors + flagErrors + indexErrors + entryErrors + otherErrors;
    $display("Errors: address %0d, flag %0d, index %0d, entry %0d, other %0d",
             addrErrors, flagErrors, indexErrors, entryErrors, otherErrors);
    if (totalErrors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== bench/mmuTlb_tests.txt ====
# Hex fields. W idx vpn2 pfn1 d1 v1 pfn0 d0 v0 | X | R idx <fields as W> | F addr phys miss
# D addr store phys miss fault idx | C idx <fields as W> <fields as D> | P <F fields> <D fields>
# Nothing is valid after reset.
F 00400010 00000000 1
D 00400010 0 00000000 1 0 0
# Entry 0 has both halves valid; only the low 20 PFN bits reach the address.
W 0 00200 000123 1 1 F00456 0 1
R 0 00200 000123 1 1 F00456 0 1
F 00400010 00456010 0
F 00401020 00123020 0
# Entry 1 has only its odd half valid.
W 1 08000 00ABCD 1 1 011111 1 0
R 1 08000 00ABCD 1 1 011111 1 0
F 10001abc 0ABCDabc 0
F 10000abc 00000000 1
D 10000abc 0 00000000 1 0 0
# Same vpn2 in entries 9 and 5, the lower index wins.
W 9 10000 000000 0 0 000999 1 1
D 20000040 0 00999040 0 0 9
W 5 10000 000000 0 0 000555 1 1
D 20000040 1 00555040 0 0 5
D 20001040 0 00000000 1 0 0
R 9 10000 000000 0 0 000999 1 1
# Dirty bits of entry 0.
D 00400010 1 00456010 0 1 0
D 00400010 0 00456010 0 0 0
D 00401020 1 00123020 0 0 0
D 10000abc 1 00000000 1 0 0
# Unmapped window.
F 80001234 00001234 0
D A0345678 1 00345678 0 0 0
D BFFFFFFC 0 1FFFFFFC 0 0 0
F 9FC00000 1FC00000 0
F C0000000 00000000 1
F 7FFFF000 00000000 1
# A lookup in the cycle of a write sees the old entry.
W 3 18000 000000 0 0 003333 1 1
D 30000000 0 03333000 0 0 3
C 3 18000 000000 0 0 004444 1 1 30000008 0 03333008 0 0 3
D 30000008 0 04444008 0 0 3
C 7 20000 000000 0 0 007777 0 1 40000010 1 00000000 1 0 0
D 40000010 1 07777010 0 1 7
F 40000010 07777010 0
# Back-to-back fetch and data requests.
P 00401020 00123020 0 10000abc 0 00000000 1 0 0
P 10000abc 00000000 1 20000040 1 00555040 0 0 5
P 80000010 00000010 0 00400010 1 00456010 0 1 0
# Flush clears every valid bit.
X
F 00400010 00000000 1
D 20000040 0 00000000 1 0 0
F 10001abc 00000000 1
D 30000008 1 00000000 1 0 0
F 40000010 00000000 1
F 80000010 00000010 0
R 0 00200 000123 1 0 F00456 0 0
R 5 10000 000000 0 0 000555 1 0
# Writes work again after a flush.
W 2 00200 000ABC 1 1 000DEF 1 1
F 00401020 00ABC020 0
D 00400010 1 00DEF010 0 0 2

// ==== verilog.f ====
+incdir+verilog
verilog/tlbPkg.sv
verilog/tlbEntryFile.sv
verilog/tlbLookup.sv
verilog/mmuTlb.sv
bench/mmuTlb_assert.sv
bench/mmuTlbTb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the MMU testbench with Verilator and runs it.
set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -f verilog.f --top-module mmuTlbTb -o mmuTlbSim

./obj_dir/mmuTlbSim | tee "$LOG"

if grep -q '^\*\* PASS \*\*$' "$LOG"; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed, see $LOG"
  exit 1
fi
